//--- project.f
verilog/loop_pkg.sv
verilog/loop_regs.sv
verilog/seq_reader.sv
verilog/seq_writer.sv
verilog/sample_mem.sv
verilog/loop_top.sv
testbench/tb_clock.sv
testbench/loop_chk.sv
testbench/loop_tb.sv

//--- Makefile
# Verilator build and run for the sample loop testbench

VERILATOR ?= verilator
TOP       ?= loop_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/loop_tb.sv
// Directed testbench for the sample loop top level, run as the simulation top
`default_nettype none

module loop_tb import loop_pkg::*; ();

   // ------------------------------------------------------------------
   // Limits, in clock cycles
   // ------------------------------------------------------------------
   localparam int BUS_LIMIT  = 200;
   localparam int POLL_LIMIT = 400;
   localparam int T_REGS     = 60;
   localparam int T_WINDOW   = 200;
   localparam int T_PLAY     = 200;
   localparam int T_CAPTURE  = 400;
   localparam int T_CONCUR   = 800;
   localparam int TIMEOUT_CYCLES = 2 * (T_REGS + T_WINDOW + T_PLAY + T_CAPTURE + T_CONCUR) + 20;

   localparam int     WIN_COUNT = 16;
   localparam waddr_t PLAY_LAST = 10'd7;
   localparam word_t  MARKER    = 32'hC0DE_5A17;

   logic     clk;
   logic     reset;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   wb_addr_t wb_adr;
   word_t    wb_dat_w;
   word_t    wb_dat_r;
   logic     wb_ack;
   sample_t  adc;
   sample_t  dac;
   logic     dac_valid;

   int       err_count;
   int       check_count;
   word_t    lcg_state;
   word_t    model [MEM_WORDS];
   waddr_t   win_addr [WIN_COUNT];

   tb_clock clock_i (
      .clk_o   (clk),
      .reset_o (reset)
   );

   loop_top dut_i (
      .clkcomm_i   (clk),
      .reset_i     (reset),
      .wb_cyc_i    (wb_cyc),
      .wb_stb_i    (wb_stb),
      .wb_we_i     (wb_we),
      .wb_adr_i    (wb_adr),
      .wb_dat_i    (wb_dat_w),
      .wb_dat_o    (wb_dat_r),
      .wb_ack_o    (wb_ack),
      .adc_i       (adc),
      .dac_o       (dac),
      .dac_valid_o (dac_valid)
   );

   // Free-running ADC count
   always @(negedge clk) begin
      adc <= adc + 8'd1;
   end

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic compare(input string name, input word_t exp, input word_t act);
      check_count++;
      if (exp !== act) begin
         err_count++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_failure(input string what);
      err_count++;
      $display("FAILURE: %s", what);
   endtask

   // One Wishbone classic cycle, started and ended on falling edges
   task automatic bus_cycle(input wb_addr_t adr, input logic we, input word_t wdata,
                            output word_t rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      @(negedge clk);
      while (!wb_ack && waited < BUS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!wb_ack) begin
         report_failure("Wishbone cycle was never acknowledged");
         rdata = '0;
      end else begin
         rdata = wb_dat_r;
      end
      // Hold the cycle over the edge that sees ack
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input waddr_t r, input word_t d);
      word_t unused;
      bus_cycle({1'b0, r}, 1'b1, d, unused);
   endtask

   task automatic read_reg(input waddr_t r, output word_t d);
      bus_cycle({1'b0, r}, 1'b0, '0, d);
   endtask

   task automatic write_window(input waddr_t a, input word_t d);
      word_t unused;
      bus_cycle({1'b1, a}, 1'b1, d, unused);
      model[a] = d;
   endtask

   task automatic read_window(input waddr_t a, output word_t d);
      bus_cycle({1'b1, a}, 1'b0, '0, d);
   endtask

   // Samples follow words 0 to last, low byte first, with wrap
   task automatic watch_playback(input string name, input int last, input int count);
      int      waited;
      int      w;
      sample_t exp_s;
      waited = 0;
      while (!dac_valid && waited < BUS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!dac_valid) begin
         report_failure("Playback never raised dac_valid_o");
      end else begin
         for (int k = 0; k < count; k++) begin
            if (!dac_valid) begin
               report_failure("dac_valid_o dropped during playback");
               break;
            end
            w     = (k / SAMPLES_PER_WORD) % (last + 1);
            exp_s = model[w][8 * (k % SAMPLES_PER_WORD) +: 8];
            compare(name, word_t'(exp_s), word_t'(dac));
            @(negedge clk);
         end
      end
   endtask

   task automatic wait_cap_done();
      int    polls;
      word_t d;
      polls = 0;
      d     = '0;
      while (!d[0] && polls < POLL_LIMIT) begin
         read_reg(REG_STATUS, d);
         polls++;
      end
      if (!d[0]) report_failure("Capture never reported done in STATUS");
   endtask

   // Captured bytes must continue the ADC count without a gap
   task automatic check_capture(input string name, input waddr_t base, input waddr_t last);
      word_t   w;
      sample_t prev;
      prev = '0;
      for (int a = int'(base); a <= int'(last); a++) begin
         read_window(waddr_t'(a), w);
         for (int b = 1; b < SAMPLES_PER_WORD; b++) begin
            compare(name, word_t'(sample_t'(w[8 * (b - 1) +: 8] + 8'd1)),
                    word_t'(w[8 * b +: 8]));
         end
         if (a != int'(base)) compare(name, word_t'(sample_t'(prev + 8'd1)), word_t'(w[7:0]));
         prev = w[31:24];
      end
   endtask

   // ------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------
   task automatic reset_and_registers();
      word_t d;
      word_t v;
      compare("reset_regs", '0, word_t'(dac_valid));
      read_reg(REG_STATUS, d);
      compare("reset_regs", '0, d);
      read_reg(REG_CTRL, d);
      compare("reset_regs", '0, d);
      read_reg(REG_PLAY_LAST, d);
      compare("reset_regs", '0, d);
      // Configuration fields are 10 bits wide
      v = next_rand() & 32'h3FF;
      write_reg(REG_PLAY_LAST, v);
      read_reg(REG_PLAY_LAST, d);
      compare("reset_regs", v, d);
      v = next_rand() & 32'h3FF;
      write_reg(REG_CAP_BASE, v);
      read_reg(REG_CAP_BASE, d);
      compare("reset_regs", v, d);
      v = next_rand() & 32'h3FF;
      write_reg(REG_CAP_LAST, v);
      read_reg(REG_CAP_LAST, d);
      compare("reset_regs", v, d);
   endtask

   task automatic window_access();
      word_t d;
      for (int i = 0; i < WIN_COUNT; i++) begin
         win_addr[i] = 10'd64 + waddr_t'(next_rand() % 32'd400);
         write_window(win_addr[i], next_rand());
      end
      for (int i = 0; i < WIN_COUNT; i++) begin
         read_window(win_addr[i], d);
         compare("window", model[win_addr[i]], d);
      end
   endtask

   task automatic playback_run();
      for (int a = 0; a <= int'(PLAY_LAST); a++) begin
         write_window(waddr_t'(a), next_rand());
      end
      write_reg(REG_PLAY_LAST, word_t'(PLAY_LAST));
      write_reg(REG_CTRL, 32'd1);
      // Three passes over the region
      watch_playback("playback", int'(PLAY_LAST), 3 * (int'(PLAY_LAST) + 1) * SAMPLES_PER_WORD);
      write_reg(REG_CTRL, 32'd0);
   endtask

   task automatic capture_run();
      word_t d;
      write_window(10'd532, MARKER);
      write_reg(REG_CAP_BASE, 32'd500);
      write_reg(REG_CAP_LAST, 32'd531);
      write_reg(REG_CTRL, 32'd2);
      wait_cap_done();
      write_reg(REG_CTRL, 32'd0);
      check_capture("capture", 10'd500, 10'd531);
      read_window(10'd532, d);
      compare("capture", MARKER, d);
   endtask

   task automatic concurrent_traffic();
      word_t d;
      write_reg(REG_PLAY_LAST, word_t'(PLAY_LAST));
      write_reg(REG_CAP_BASE, 32'd600);
      write_reg(REG_CAP_LAST, 32'd663);
      write_reg(REG_CTRL, 32'd3);
      fork
         watch_playback("concurrent", int'(PLAY_LAST), 160);
         begin
            for (int i = 0; i < WIN_COUNT; i++) begin
               read_window(win_addr[i], d);
               compare("concurrent", model[win_addr[i]], d);
            end
            wait_cap_done();
         end
      join
      write_reg(REG_CTRL, 32'd0);
      check_capture("concurrent", 10'd600, 10'd663);
   endtask

   // ------------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------------
   initial begin
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      adc         = '0;
      err_count   = 0;
      check_count = 0;
      lcg_state   = 32'd97281;
      wait (!reset);
      repeat (2) @(negedge clk);

      reset_and_registers();
      window_access();
      playback_run();
      capture_run();
      concurrent_traffic();

      $display("Checks run: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/loop_chk.sv
// Protocol and arbitration assertions, bound into the DUT top level
`default_nettype none

module loop_chk (
   input wire clk_i,
   input wire reset_i,
   input wire wr_gnt_i,
   input wire rd_gnt_i,
   input wire bus_gnt_i,
   input wire wb_cyc_i,
   input wire wb_stb_i,
   input wire wb_ack_i,
   input wire dac_valid_i
);

   // Single-port RAM, so never more than one grant
   one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0({wr_gnt_i, rd_gnt_i, bus_gnt_i}))
      else $error("More than one memory grant in the same cycle");

   // Wishbone classic ack only inside an active cycle
   ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
      else $error("Wishbone ack outside of cyc and stb");

   no_dac_in_reset: assert property (@(posedge clk_i)
      (reset_i && $past(reset_i)) |-> !dac_valid_i)
      else $error("DAC valid high while in reset");

endmodule

bind loop_top loop_chk chk_i (
   .clk_i       (clkcomm_i),
   .reset_i     (reset_i),
   .wr_gnt_i    (wr_gnt),
   .rd_gnt_i    (rd_gnt),
   .bus_gnt_i   (bus_gnt),
   .wb_cyc_i    (wb_cyc_i),
   .wb_stb_i    (wb_stb_i),
   .wb_ack_i    (wb_ack_o),
   .dac_valid_i (dac_valid_o)
);

`default_nettype wire

//--- testbench/tb_clock.sv
// Testbench clock and reset source, instantiated once by the testbench top
`default_nettype none

module tb_clock (
   output logic clk_o,
   output logic reset_o
);

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 8;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset released on a falling edge, like every other input
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- verilog/loop_top.sv
// Top level of the sample loop, connects registers, streamers and the shared sample RAM
`default_nettype none

module loop_top import loop_pkg::*; (
   input  wire              clkcomm_i,
   input  wire              reset_i,

   // Wishbone classic slave
   input  wire              wb_cyc_i,
   input  wire              wb_stb_i,
   input  wire              wb_we_i,
   input  wire wb_addr_t    wb_adr_i,
   input  wire word_t       wb_dat_i,
   output word_t            wb_dat_o,
   output logic             wb_ack_o,

   // Converters
   input  wire sample_t     adc_i,
   output sample_t          dac_o,
   output logic             dac_valid_o
);

   // ------------------------------------------------------------------
   // Wires
   // ------------------------------------------------------------------
   loop_cfg_t cfg;
   logic      cap_done;

   mem_req_t  wr_req;
   mem_req_t  rd_req;
   mem_req_t  bus_req;
   logic      wr_gnt;
   logic      rd_gnt;
   logic      bus_gnt;
   logic      rvalid_rd;
   logic      rvalid_bus;
   word_t     rdata;

   // ------------------------------------------------------------------
   // Instances
   // ------------------------------------------------------------------
   loop_regs regs_i (
      .clkcomm_i  (clkcomm_i),
      .reset_i    (reset_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .cap_done_i (cap_done),
      .cfg_o      (cfg),
      .bus_req_o  (bus_req),
      .gnt_i      (bus_gnt),
      .rvalid_i   (rvalid_bus),
      .rdata_i    (rdata)
   );

   seq_reader reader_i (
      .clkcomm_i   (clkcomm_i),
      .reset_i     (reset_i),
      .cfg_i       (cfg),
      .req_o       (rd_req),
      .gnt_i       (rd_gnt),
      .rvalid_i    (rvalid_rd),
      .rdata_i     (rdata),
      .dac_o       (dac_o),
      .dac_valid_o (dac_valid_o)
   );

   seq_writer writer_i (
      .clkcomm_i  (clkcomm_i),
      .reset_i    (reset_i),
      .cfg_i      (cfg),
      .adc_i      (adc_i),
      .req_o      (wr_req),
      .gnt_i      (wr_gnt),
      .cap_done_o (cap_done)
   );

   sample_mem mem_i (
      .clkcomm_i    (clkcomm_i),
      .reset_i      (reset_i),
      .wr_req_i     (wr_req),
      .rd_req_i     (rd_req),
      .bus_req_i    (bus_req),
      .wr_gnt_o     (wr_gnt),
      .rd_gnt_o     (rd_gnt),
      .bus_gnt_o    (bus_gnt),
      .rvalid_rd_o  (rvalid_rd),
      .rvalid_bus_o (rvalid_bus),
      .rdata_o      (rdata)
   );

endmodule

`default_nettype wire

//--- verilog/sample_mem.sv
// Fixed-priority arbiter and single-port sample RAM shared by capture, playback and the bus
`default_nettype none

module sample_mem import loop_pkg::*; (
   input  wire              clkcomm_i,
   input  wire              reset_i,

   // Requesters in falling priority
   input  wire mem_req_t    wr_req_i,
   input  wire mem_req_t    rd_req_i,
   input  wire mem_req_t    bus_req_i,

   output logic             wr_gnt_o,
   output logic             rd_gnt_o,
   output logic             bus_gnt_o,

   // Read return, one clock after the grant
   output logic             rvalid_rd_o,
   output logic             rvalid_bus_o,
   output word_t            rdata_o
);

   word_t    ram [MEM_WORDS];
   word_t    rdata_q;
   mem_req_t sel;
   logic     rv_rd_q;
   logic     rv_bus_q;

   // ------------------------------------------------------------------
   // Arbitration
   // ------------------------------------------------------------------
   assign wr_gnt_o  = wr_req_i.valid;
   assign rd_gnt_o  = rd_req_i.valid & ~wr_req_i.valid;
   assign bus_gnt_o = bus_req_i.valid & ~wr_req_i.valid & ~rd_req_i.valid;

   always_comb begin
      if (wr_gnt_o) begin
         sel = wr_req_i;
      end else if (rd_gnt_o) begin
         sel = rd_req_i;
      end else begin
         // Idle when the bus is not asking either
         sel = bus_req_i;
      end
   end

   // ------------------------------------------------------------------
   // RAM
   // ------------------------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (sel.valid) begin
         if (sel.we) ram[sel.addr] <= sel.data;
         else rdata_q <= ram[sel.addr];
      end
   end

   // Which requester owns the word coming out next cycle
   always_ff @(posedge clkcomm_i) begin
      if (reset_i) begin
         rv_rd_q  <= 1'b0;
         rv_bus_q <= 1'b0;
      end else begin
         rv_rd_q  <= rd_gnt_o & ~rd_req_i.we;
         rv_bus_q <= bus_gnt_o & ~bus_req_i.we;
      end
   end

   assign rvalid_rd_o  = rv_rd_q;
   assign rvalid_bus_o = rv_bus_q;
   assign rdata_o      = rdata_q;

endmodule

`default_nettype wire

//--- verilog/seq_writer.sv
// Capture streamer: packs four ADC samples per word and writes them in sequence
`default_nettype none

module seq_writer import loop_pkg::*; (
   input  wire              clkcomm_i,
   input  wire              reset_i,
   input  wire loop_cfg_t   cfg_i,
   input  wire sample_t     adc_i,

   output mem_req_t         req_o,
   input  wire              gnt_i,
   output logic             cap_done_o
);

   logic   cap_en_q;
   logic   done_q;
   lane_t  lane_q;
   logic   req_valid_q;
   waddr_t wr_addr_q;
   word_t  shift_q;
   word_t  req_data_q;
   word_t  next_word;
   logic   run;
   logic   post;

   assign run  = cfg_i.cap_en & cap_en_q & ~done_q;
   assign post = run & (lane_q == LAST_LANE);

   // Newest sample enters at the top byte
   assign next_word = {adc_i, shift_q[$bits(word_t)-1:$bits(sample_t)]};

   assign req_o      = '{valid: req_valid_q, we: 1'b1, addr: wr_addr_q, data: req_data_q};
   assign cap_done_o = done_q;

   // ------------------------------------------------------------------
   // Capture control
   // ------------------------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (reset_i) begin
         cap_en_q    <= 1'b0;
         done_q      <= 1'b0;
         lane_q      <= '0;
         req_valid_q <= 1'b0;
         wr_addr_q   <= '0;
      end else begin
         cap_en_q <= cfg_i.cap_en;
         if (run) lane_q <= lane_q + 1'b1;
         if (post) req_valid_q <= 1'b1;

         // Highest priority, so the grant comes in the cycle of the request
         if (gnt_i) begin
            req_valid_q <= 1'b0;
            if (wr_addr_q == cfg_i.cap_last) done_q <= 1'b1;
            else wr_addr_q <= wr_addr_q + 1'b1;
         end

         // Rising cap_en restarts at cap_base
         if (cfg_i.cap_en && !cap_en_q) begin
            wr_addr_q <= cfg_i.cap_base;
            done_q    <= 1'b0;
            lane_q    <= '0;
         end
      end
   end

   // Sample packing
   always_ff @(posedge clkcomm_i) begin
      if (run) shift_q <= next_word;
      if (post) req_data_q <= next_word;
   end

endmodule

`default_nettype wire

//--- verilog/seq_reader.sv
// Playback streamer: prefetches words from the bottom region and emits one DAC sample per clock
`default_nettype none

module seq_reader import loop_pkg::*; (
   input  wire              clkcomm_i,
   input  wire              reset_i,
   input  wire loop_cfg_t   cfg_i,

   output mem_req_t         req_o,
   input  wire              gnt_i,
   input  wire              rvalid_i,
   input  wire word_t       rdata_i,

   output sample_t          dac_o,
   output logic             dac_valid_o
);

   logic     run_q;
   logic     req_valid_q;
   logic     infl_q;
   waddr_t   rd_addr_q;
   word_t    buf_q [PREFETCH_WORDS];
   pf_idx_t  wr_idx_q;
   pf_idx_t  rd_idx_q;
   pf_cnt_t  count_q;
   lane_t    lane_q;
   logic     start;
   logic     need;
   logic     push;
   logic     pop;

   // New run once play_en is seen and nothing is outstanding
   assign start = cfg_i.play_en & ~run_q & ~req_valid_q & ~infl_q;
   assign need  = run_q & cfg_i.play_en & ~req_valid_q &
                  (int'(count_q) + int'(infl_q) < PREFETCH_WORDS);

   // Reads left over from an earlier run are dropped
   assign push = rvalid_i & run_q;

   assign dac_valid_o = run_q & cfg_i.play_en & (count_q != '0);
   assign pop         = dac_valid_o & (lane_q == LAST_LANE);
   assign dac_o       = buf_q[rd_idx_q][$bits(sample_t)*lane_q +: $bits(sample_t)];

   assign req_o = '{valid: req_valid_q, we: 1'b0, addr: rd_addr_q, data: '0};

   // ------------------------------------------------------------------
   // Prefetch and output control
   // ------------------------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (reset_i) begin
         run_q       <= 1'b0;
         req_valid_q <= 1'b0;
         infl_q      <= 1'b0;
         rd_addr_q   <= PLAY_BASE;
         wr_idx_q    <= '0;
         rd_idx_q    <= '0;
         count_q     <= '0;
         lane_q      <= '0;
      end else begin
         // Grant to rvalid is always one clock
         infl_q <= gnt_i;
         if (!cfg_i.play_en) run_q <= 1'b0;
         else if (start) run_q <= 1'b1;

         if (gnt_i) begin
            req_valid_q <= 1'b0;
            rd_addr_q   <= (rd_addr_q == cfg_i.play_last) ? PLAY_BASE : rd_addr_q + 1'b1;
         end else if (need) begin
            req_valid_q <= 1'b1;
         end

         if (start) begin
            rd_addr_q <= PLAY_BASE;
            wr_idx_q  <= '0;
            rd_idx_q  <= '0;
            count_q   <= '0;
            lane_q    <= '0;
         end else begin
            if (push) wr_idx_q <= wr_idx_q + 1'b1;
            if (pop) rd_idx_q <= rd_idx_q + 1'b1;
            if (dac_valid_o) lane_q <= lane_q + 1'b1;
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
         end
      end
   end

   // Word buffer
   always_ff @(posedge clkcomm_i) begin
      if (push) buf_q[wr_idx_q] <= rdata_i;
   end

endmodule

`default_nettype wire

//--- verilog/loop_regs.sv
// Wishbone slave for the control registers, also forwards window accesses to the sample RAM
`default_nettype none

module loop_regs import loop_pkg::*; (
   input  wire              clkcomm_i,
   input  wire              reset_i,

   // Wishbone classic slave
   input  wire              wb_cyc_i,
   input  wire              wb_stb_i,
   input  wire              wb_we_i,
   input  wire wb_addr_t    wb_adr_i,
   input  wire word_t       wb_dat_i,
   output word_t            wb_dat_o,
   output logic             wb_ack_o,

   input  wire              cap_done_i,
   output loop_cfg_t        cfg_o,

   // Memory window port
   output mem_req_t         bus_req_o,
   input  wire              gnt_i,
   input  wire              rvalid_i,
   input  wire word_t       rdata_i
);

   loop_cfg_t cfg_q;
   logic      ack_q;
   logic      issued_q;
   word_t     rd_q;
   word_t     reg_rdata;
   logic      reg_sel;
   logic      win_sel;

   assign reg_sel = wb_cyc_i & wb_stb_i & ~wb_adr_i[WB_WIN_BIT];
   assign win_sel = wb_cyc_i & wb_stb_i & wb_adr_i[WB_WIN_BIT];

   // ------------------------------------------------------------------
   // Memory window request, held until granted
   // ------------------------------------------------------------------
   always_comb begin
      bus_req_o.valid = win_sel & ~issued_q;
      bus_req_o.we    = wb_we_i;
      bus_req_o.addr  = wb_adr_i[$bits(waddr_t)-1:0];
      bus_req_o.data  = wb_dat_i;
   end

   // Window reads finish in the rvalid cycle
   assign wb_ack_o = ack_q | rvalid_i;
   assign wb_dat_o = rvalid_i ? rdata_i : rd_q;
   assign cfg_o    = cfg_q;

   // Register read mux
   always_comb begin
      reg_rdata = '0;
      case (wb_adr_i[$bits(waddr_t)-1:0])
         REG_CTRL:      reg_rdata = word_t'({cfg_q.cap_en, cfg_q.play_en});
         REG_PLAY_LAST: reg_rdata = word_t'(cfg_q.play_last);
         REG_CAP_BASE:  reg_rdata = word_t'(cfg_q.cap_base);
         REG_CAP_LAST:  reg_rdata = word_t'(cfg_q.cap_last);
         REG_STATUS:    reg_rdata = word_t'(cap_done_i);
         default:       reg_rdata = '0;
      endcase
   end

   // ------------------------------------------------------------------
   // Control state
   // ------------------------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (reset_i) begin
         cfg_q    <= '0;
         ack_q    <= 1'b0;
         issued_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         // Register cycle, answered one clock later
         if (reg_sel && !ack_q) begin
            ack_q <= 1'b1;
            if (wb_we_i) begin
               case (wb_adr_i[$bits(waddr_t)-1:0])
                  REG_CTRL: begin
                     cfg_q.play_en <= wb_dat_i[0];
                     cfg_q.cap_en  <= wb_dat_i[1];
                  end
                  REG_PLAY_LAST: cfg_q.play_last <= wb_dat_i[$bits(waddr_t)-1:0];
                  REG_CAP_BASE:  cfg_q.cap_base  <= wb_dat_i[$bits(waddr_t)-1:0];
                  REG_CAP_LAST:  cfg_q.cap_last  <= wb_dat_i[$bits(waddr_t)-1:0];
                  default: ;
               endcase
            end
         end
         // Window cycle
         if (gnt_i) begin
            issued_q <= 1'b1;
            if (wb_we_i) ack_q <= 1'b1;
         end
         if (wb_ack_o) issued_q <= 1'b0;
      end
   end

   // Read data for register cycles
   always_ff @(posedge clkcomm_i) begin
      if (reg_sel && !ack_q) rd_q <= reg_rdata;
   end

endmodule

`default_nettype wire

//--- verilog/loop_pkg.sv
// Shared widths, memory request format and register map, imported by every RTL module
`default_nettype none

package loop_pkg;

   // ------------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------------
   localparam int MEM_WORDS        = 1024;
   localparam int SAMPLES_PER_WORD = 4;
   localparam int PREFETCH_WORDS   = 2;

   // One converter sample
   typedef logic [7:0]  sample_t;
   // Four samples, lowest byte is the oldest
   typedef logic [31:0] word_t;
   typedef logic [9:0]  waddr_t;
   // Top bit selects the memory window
   typedef logic [10:0] wb_addr_t;

   // Byte position of a sample inside a word
   typedef logic [$clog2(SAMPLES_PER_WORD)-1:0] lane_t;

   // Playback buffer slot and fill level
   typedef logic [$clog2(PREFETCH_WORDS)-1:0]   pf_idx_t;
   typedef logic [$clog2(PREFETCH_WORDS+1)-1:0] pf_cnt_t;

   localparam lane_t LAST_LANE  = lane_t'(SAMPLES_PER_WORD - 1);
   localparam int    WB_WIN_BIT = $bits(wb_addr_t) - 1;

   // Playback region always begins at the bottom of memory
   localparam waddr_t PLAY_BASE = '0;

   // ------------------------------------------------------------------
   // Register map, word offsets below the window bit
   // ------------------------------------------------------------------
   localparam waddr_t REG_CTRL      = 10'd0;
   localparam waddr_t REG_PLAY_LAST = 10'd1;
   localparam waddr_t REG_CAP_BASE  = 10'd2;
   localparam waddr_t REG_CAP_LAST  = 10'd3;
   localparam waddr_t REG_STATUS    = 10'd4;

   // ------------------------------------------------------------------
   // Bundles
   // ------------------------------------------------------------------
   // One request towards the sample RAM, 44 bits
   typedef struct packed {
      logic   valid;
      logic   we;
      waddr_t addr;
      word_t  data;
   } mem_req_t;

   // Streamer configuration, 32 bits
   typedef struct packed {
      logic   play_en;
      logic   cap_en;
      waddr_t play_last;
      waddr_t cap_base;
      waddr_t cap_last;
   } loop_cfg_t;

endpackage

`default_nettype wire
